// ==== act_fetch_ctrl.sv ====
`default_nettype none

`include "gbf_settings.svh"

module act_fetch_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  act_pkg::patch_len_t cfg_num_words,
    input  logic                data_avail,
    input  logic                unpacker_empty,
    input  logic                act_get,
    output logic                rd_en,
    output gbf_pkg::gbf_addr_t  rd_addr,
    output logic                load,
    output logic                patch_rst,
    output logic                busy,
    output logic                done
);
    import act_pkg::*;

    patch_len_t num_words;
    patch_len_t fetched_words;
    patch_len_t taken_words;
    lane_idx_t  taken_lane;
    logic       fetch_cond;
    logic       fetch_cond_d;
    logic       last_get;

    // ==============================
    // fetch side
    // ==============================

    assign fetch_cond = busy && (fetched_words < num_words) && unpacker_empty && data_avail;

    // rising edge only, the load of the previous read is still in flight
    assign rd_en = fetch_cond && !fetch_cond_d;

    // last lane of the last word ends the patch
    assign last_get = busy && act_get && (taken_lane == lane_idx_t'(ACT_LANES - 1))
                      && (taken_words == num_words - 1'b1);
    assign patch_rst = last_get;

    always_ff @(posedge clk) begin
        if (start && !busy) begin
            num_words <= cfg_num_words;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (last_get) begin
            busy <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
        end
    end

    // rewind to address 0 for the next patch
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetched_words <= '0;
            rd_addr       <= '0;
        end else if (patch_rst) begin
            fetched_words <= '0;
            rd_addr       <= '0;
        end else if (rd_en) begin
            fetched_words <= fetched_words + 1'b1;
            rd_addr       <= rd_addr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_cond_d <= 1'b0;
            load         <= 1'b0;
            done         <= 1'b0;
        end else begin
            fetch_cond_d <= fetch_cond;
            load         <= rd_en;
            done         <= last_get;
        end
    end

    // ==============================
    // consumer side
    // ==============================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            taken_lane  <= '0;
            taken_words <= '0;
        end else if (patch_rst) begin
            taken_lane  <= '0;
            taken_words <= '0;
        end else if (busy && act_get) begin
            taken_lane <= taken_lane + 1'b1;
            if (taken_lane == lane_idx_t'(ACT_LANES - 1)) begin
                taken_words <= taken_words + 1'b1;
            end
        end
    end

    a_patch_len_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        (start && !busy) |-> (cfg_num_words != '0));

endmodule

`default_nettype wire

// ==== act_gbf_sram.sv ====
`default_nettype none

`include "gbf_settings.svh"

module act_gbf_sram (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               wr_en,
    input  gbf_pkg::gbf_addr_t wr_addr,
    input  gbf_pkg::gbf_word_t wr_data,
    input  logic               rd_en,
    input  gbf_pkg::gbf_addr_t rd_addr,
    output gbf_pkg::gbf_word_t rd_data
);
    import gbf_pkg::*;

    gbf_word_t mem [2**`GBF_ADDR_WIDTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read data holds between reads
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

    // single port macro underneath, fetch control must back off on writes
    a_no_rd_wr_collision: assert property (@(posedge clk) disable iff (!rst_n)
        !(rd_en && wr_en));

endmodule

`default_nettype wire

// ==== act_gbf_top.sv ====
`default_nettype none

`include "gbf_settings.svh"

module act_gbf_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wr_en,
    input  gbf_pkg::gbf_addr_t  wr_addr,
    input  gbf_pkg::gbf_word_t  wr_data,
    input  logic                start,
    input  act_pkg::patch_len_t cfg_num_words,
    input  logic                act_get,
    output logic                act_ready,
    output act_pkg::act_t       act,
    output logic                busy,
    output logic                done
);
    import gbf_pkg::*;

    logic      rd_en;
    gbf_addr_t rd_addr;
    gbf_word_t rd_data;
    logic      data_avail;
    logic      unpacker_empty;
    logic      load;
    logic      patch_rst;

    // ==============================
    // buffer and occupancy
    // ==============================

    act_gbf_sram i_sram (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    gbf_occupancy i_occupancy (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_en      (wr_en),
        .rd_en      (rd_en),
        .patch_rst  (patch_rst),
        .data_avail (data_avail)
    );

    // ==============================
    // fetch control and unpacking
    // ==============================

    act_fetch_ctrl i_fetch_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .start          (start),
        .cfg_num_words  (cfg_num_words),
        .data_avail     (data_avail),
        .unpacker_empty (unpacker_empty),
        .act_get        (act_get),
        .rd_en          (rd_en),
        .rd_addr        (rd_addr),
        .load           (load),
        .patch_rst      (patch_rst),
        .busy           (busy),
        .done           (done)
    );

    act_unpacker i_unpacker (
        .clk            (clk),
        .rst_n          (rst_n),
        .load           (load),
        .rd_data        (rd_data),
        .act_get        (act_get),
        .act_ready      (act_ready),
        .unpacker_empty (unpacker_empty),
        .act            (act)
    );

endmodule

`default_nettype wire

// ==== act_pkg.sv ====
`default_nettype none

`include "gbf_settings.svh"

// activation side types
package act_pkg;

    // lanes packed in one port word
    localparam int ACT_LANES = `GBF_PORT_WIDTH / `GBF_ACT_WIDTH;

    typedef logic [`GBF_ACT_WIDTH-1:0] act_t;

    // lane 0 is the most significant lane of the word
    typedef logic [$clog2(ACT_LANES)-1:0] lane_idx_t;

    typedef logic [`GBF_PATCH_WIDTH-1:0] patch_len_t;

endpackage

`default_nettype wire

// ==== act_unpacker.sv ====
`default_nettype none

`include "gbf_settings.svh"

module act_unpacker (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               load,
    input  gbf_pkg::gbf_word_t rd_data,
    input  logic               act_get,
    output logic               act_ready,
    output logic               unpacker_empty,
    output act_pkg::act_t      act
);
    import act_pkg::*;

    logic [`GBF_PORT_WIDTH-1:0] word;
    lane_idx_t                  lane;
    lane_idx_t                  lane_sel;
    logic                       full;

    // ==============================
    // word hold and lane walk
    // ==============================

    always_ff @(posedge clk) begin
        if (load) begin
            word <= rd_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full <= 1'b0;
            lane <= '0;
        end else if (load) begin
            full <= 1'b1;
            lane <= '0;
        end else if (act_get) begin
            lane <= lane + 1'b1;
            // fourth get drains the word
            if (lane == lane_idx_t'(ACT_LANES - 1)) begin
                full <= 1'b0;
            end
        end
    end

    // left first, lane 0 sits in the top bits
    assign lane_sel = lane_idx_t'(ACT_LANES - 1) - lane;
    assign act      = word[lane_sel*`GBF_ACT_WIDTH +: `GBF_ACT_WIDTH];

    assign act_ready      = full;
    assign unpacker_empty = !full;

    a_get_when_ready: assert property (@(posedge clk) disable iff (!rst_n)
        act_get |-> act_ready);

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+.
gbf_pkg.sv
act_pkg.sv
act_gbf_sram.sv
gbf_occupancy.sv
act_fetch_ctrl.sv
act_unpacker.sv
act_gbf_top.sv
tb_clock_gen.sv
tb_act_gbf.sv

// ==== gbf_occupancy.sv ====
`default_nettype none

`include "gbf_settings.svh"

module gbf_occupancy (
    input  logic clk,
    input  logic rst_n,
    input  logic wr_en,
    input  logic rd_en,
    input  logic patch_rst,
    output logic data_avail
);
    import gbf_pkg::*;

    localparam gbf_count_t FULL_COUNT = gbf_count_t'(2 ** `GBF_ADDR_WIDTH);

    gbf_count_t count;

    // ==============================
    // word count
    // ==============================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (patch_rst) begin
            count <= '0;
        end else if (wr_en && !rd_en) begin
            count <= count + 1'b1;
        end else if (rd_en && !wr_en) begin
            count <= count - 1'b1;
        end
    end

    // write wins the port, no read offered in a write cycle
    assign data_avail = (count != '0) && !wr_en;

    // ==============================
    // checks
    // ==============================

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> (count != FULL_COUNT));

    // reads come from the fetch controller, gated by data_avail there
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        rd_en |-> (count != '0));

endmodule

`default_nettype wire

// ==== gbf_pkg.sv ====
`default_nettype none

`include "gbf_settings.svh"

// buffer side types
package gbf_pkg;

    // word address into the activation buffer
    typedef logic [`GBF_ADDR_WIDTH-1:0] gbf_addr_t;

    // one port word as written by the external writer
    typedef logic [`GBF_PORT_WIDTH-1:0] gbf_word_t;

    // occupancy, one bit wider than the address so a full buffer fits
    typedef logic [`GBF_ADDR_WIDTH:0] gbf_count_t;

endpackage

`default_nettype wire

// ==== gbf_settings.svh ====
`ifndef GBF_SETTINGS_SVH
`define GBF_SETTINGS_SVH

// ==============================
// activation buffer configuration
// ==============================

// one buffer word on the write port
`define GBF_PORT_WIDTH 32
// one activation lane
`define GBF_ACT_WIDTH 8
// 64 words deep
`define GBF_ADDR_WIDTH 6
// patch length counts up to 64 words
`define GBF_PATCH_WIDTH 7

`endif

// ==== tb_act_gbf.sv ====
`default_nettype none

module tb_act_gbf;
    timeunit 1ns;
    timeprecision 100ps;

    import gbf_pkg::*;
    import act_pkg::*;

    localparam int NUM_PATCHES    = 12;
    localparam int MAX_WORDS      = 64;
    localparam int LANES_PER_WORD = 4;
    localparam int TIMEOUT_CYCLES = NUM_PATCHES * MAX_WORDS * LANES_PER_WORD * 8;

    logic       clk;
    logic       rst_n;
    logic       wr_en;
    gbf_addr_t  wr_addr;
    gbf_word_t  wr_data;
    logic       start;
    patch_len_t cfg_num_words;
    logic       act_get;
    logic       act_ready;
    act_t       act;
    logic       busy;
    logic       done;

    // reference model and monitor state
    logic [31:0] lcg_state = 32'hab13ca19;
    act_t        expected_lanes[$];
    act_t        exp_lane;
    act_t        held_act;
    int unsigned cur_len;
    int unsigned taken_count;
    int unsigned lane_in_word;
    int unsigned done_total;
    int unsigned cycle_count;
    logic        done_due;
    logic        patch_closed;
    logic        was_ready;
    logic        was_get;
    logic        get_plan;

    tb_clock_gen i_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    act_gbf_top i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .start         (start),
        .cfg_num_words (cfg_num_words),
        .act_get       (act_get),
        .act_ready     (act_ready),
        .act           (act),
        .busy          (busy),
        .done          (done)
    );

    // ==============================
    // helpers
    // ==============================

    function automatic int unsigned random_below(input int unsigned limit);
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        // upper bits of an LCG are the better ones
        return (lcg_state >> 16) % limit;
    endfunction

    task automatic abort_run();
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input int unsigned expected,
                                   input int unsigned actual);
        $display("error: %s expected %0d actual %0d", name, expected, actual);
        abort_run();
    endtask

    task automatic report_problem(input string what);
        $display("%s", what);
        abort_run();
    endtask

    // strobes fall back to idle unless driven again on this edge
    task automatic next_cycle();
        @(posedge clk);
        start <= 1'b0;
        wr_en <= 1'b0;
    endtask

    // four lanes, most significant first
    task automatic push_word_lanes(input gbf_word_t word);
        int l;
        for (l = 0; l < LANES_PER_WORD; l++) begin
            expected_lanes.push_back(word[31 - 8 * l -: 8]);
        end
    endtask

    task automatic run_patch(input int unsigned index);
        int unsigned n;
        int unsigned idle;
        int unsigned w;
        gbf_word_t   wd;
        n = random_below(MAX_WORDS) + 1;
        next_cycle();
        start         <= 1'b1;
        cfg_num_words <= patch_len_t'(n);
        cur_len = n;
        for (w = 0; w < n; w++) begin
            idle = random_below(4);
            repeat (idle) next_cycle();
            next_cycle();
            wd[31:16] = 16'(random_below(65536));
            wd[15:0]  = 16'(random_below(65536));
            wr_en   <= 1'b1;
            wr_addr <= gbf_addr_t'(w);
            wr_data <= wd;
            push_word_lanes(wd);
        end
        next_cycle();
        while (done_total <= index) next_cycle();
    endtask

    // ==============================
    // stimulus
    // ==============================

    initial begin
        wr_en         = 1'b0;
        wr_addr       = '0;
        wr_data       = '0;
        start         = 1'b0;
        cfg_num_words = '0;
        act_get       = 1'b0;
        wait (rst_n === 1'b1);
        @(negedge clk);
        assert (!busy && !done && !act_ready)
            else report_problem("control outputs not low after reset");
        for (int p = 0; p < NUM_PATCHES; p++) begin
            run_patch(p);
        end
        $display("Test OK");
        $finish;
    end

    // consumer strobe decided at the falling edge, driven on the rising one
    always @(posedge clk) begin
        act_get <= get_plan;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            report_problem("timeout, the patches did not finish in time");
        end
    end

    // ==============================
    // monitor and consumer
    // ==============================

    initial begin
        cycle_count  = 0;
        taken_count  = 0;
        lane_in_word = 0;
        done_total   = 0;
        done_due     = 1'b0;
        patch_closed = 1'b0;
        was_ready    = 1'b0;
        was_get      = 1'b0;
        get_plan     = 1'b0;
    end

    always @(negedge clk) begin
        if (rst_n) begin
            // done only in the cycle after the last lane
            assert (done == done_due) else report_mismatch("patch_end_done", done_due, done);
            if (done) begin
                assert (!busy) else report_problem("busy still high in the done cycle");
                taken_count  = 0;
                done_total   = done_total + 1;
                patch_closed = 1'b1;
            end
            if (start) begin
                patch_closed = 1'b0;
            end
            if (patch_closed) begin
                assert (!act_ready) else report_problem("act_ready rose after done");
            end

            // held word must not move without a get
            if (was_ready && !was_get) begin
                assert (act_ready) else report_problem("act_ready dropped without act_get");
                assert (act == held_act) else report_mismatch("back_pressure", held_act, act);
            end

            done_due = 1'b0;
            get_plan = 1'b0;
            if (act_get) begin
                assert (act_ready) else report_problem("act_get driven while act_ready low");
                assert (expected_lanes.size() != 0)
                    else report_problem("lane taken before its word was written");
                exp_lane = expected_lanes.pop_front();
                assert (act == exp_lane) else report_mismatch("lane_order", exp_lane, act);
                taken_count = taken_count + 1;
                if (taken_count == LANES_PER_WORD * cur_len) begin
                    done_due = 1'b1;
                end
            end

            // the fourth get empties the word, so no get in the next cycle
            if (act_ready && !(act_get && lane_in_word == LANES_PER_WORD - 1)) begin
                get_plan = (random_below(2) == 1);
            end
            if (act_get) begin
                lane_in_word = (lane_in_word + 1) % LANES_PER_WORD;
            end

            was_ready = act_ready;
            was_get   = act_get;
            held_act  = act;
        end
    end

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 4;

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // release on a rising edge, the DUT still sees reset on that edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire
